// ==== soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Block RAM region with an exclusive limit
`define SOC_RAM_BASE 32'h0001_0000
`define SOC_RAM_LIMIT 32'h0002_0000

// LED register region with an exclusive limit
`define SOC_LED_BASE 32'h5000_0000
`define SOC_LED_LIMIT 32'h5000_0010

// Timer occupies one word
`define SOC_TIMER_ADDR 32'h5000_0050

// Number of 32-bit words in the block RAM
`define SOC_RAM_WORDS 256

// Clocks per timer tick
`define SOC_TIMER_DIV 4

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

	// Bus data word
	typedef logic [31:0] word_t;

	// Byte address on the bus
	typedef logic [31:0] addr_t;

	// Pattern shown on the red LEDs
	typedef logic [9:0] led_t;

	// Word index into the block RAM
	typedef logic [7:0] ram_index_t;

	// Transfer held by the master until ready
	typedef struct packed {
		logic  request;
		logic  rw;
		addr_t address;
		word_t wdata;
	} bus_req_t;

	// Answer from a target with a one-cycle ready strobe
	typedef struct packed {
		logic  ready;
		word_t rdata;
	} bus_rsp_t;

endpackage

// ==== bus_decoder.sv ====
`include "soc_cfg.svh"

module bus_decoder (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_bus,
	output soc_pkg::bus_rsp_t  o_bus,
	output soc_pkg::bus_req_t  o_ram_req,
	output soc_pkg::bus_req_t  o_led_req,
	output soc_pkg::bus_req_t  o_timer_req,
	input  soc_pkg::bus_rsp_t  i_ram_rsp,
	input  soc_pkg::bus_rsp_t  i_led_rsp,
	input  soc_pkg::bus_rsp_t  i_timer_rsp
);

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_RAM,
		REGION_LED,
		REGION_TIMER
	} region_e;

	region_e region;
	logic ram_hit;
	logic led_hit;
	logic timer_hit;
	logic none_ready;

	// Region bounds
	assign ram_hit = (i_bus.address >= `SOC_RAM_BASE) && (i_bus.address < `SOC_RAM_LIMIT);
	assign led_hit = (i_bus.address >= `SOC_LED_BASE) && (i_bus.address < `SOC_LED_LIMIT);
	assign timer_hit = (i_bus.address == `SOC_TIMER_ADDR);

	always_comb
	begin
		if (ram_hit)
		begin
			region = REGION_RAM;
		end
		else if (led_hit)
		begin
			region = REGION_LED;
		end
		else if (timer_hit)
		begin
			region = REGION_TIMER;
		end
		else
		begin
			region = REGION_NONE;
		end
	end

	// Each target sees only its own transfers with a region-relative address
	always_comb
	begin
		o_ram_req = i_bus;
		o_ram_req.request = i_bus.request && (region == REGION_RAM);
		o_ram_req.address = i_bus.address - `SOC_RAM_BASE;

		o_led_req = i_bus;
		o_led_req.request = i_bus.request && (region == REGION_LED);
		o_led_req.address = i_bus.address - `SOC_LED_BASE;

		o_timer_req = i_bus;
		o_timer_req.request = i_bus.request && (region == REGION_TIMER);
		o_timer_req.address = i_bus.address - `SOC_TIMER_ADDR;
	end

	// Stray addresses get a strobe of their own so the master never stalls
	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			none_ready <= 1'b0;
		end
		else
		begin
			none_ready <= i_bus.request && (region == REGION_NONE) && !none_ready;
		end
	end

	// Response back to the master
	always_comb
	begin
		case (region)
			REGION_RAM:
			begin
				o_bus = i_ram_rsp;
			end
			REGION_LED:
			begin
				o_bus = i_led_rsp;
			end
			REGION_TIMER:
			begin
				o_bus = i_timer_rsp;
			end
			default:
			begin
				o_bus.ready = none_ready;
				o_bus.rdata = '0;
			end
		endcase
	end

endmodule

// ==== block_ram.sv ====
`include "soc_cfg.svh"

module block_ram (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_req,
	output soc_pkg::bus_rsp_t  o_rsp
);

	soc_pkg::word_t mem [`SOC_RAM_WORDS];
	soc_pkg::ram_index_t index;
	soc_pkg::word_t rdata_q;
	logic ready_q;
	logic access;

	// Upper offset bits alias onto the same words
	assign index = i_req.address[$bits(soc_pkg::ram_index_t) + 1:2];

	// First cycle of a held request
	assign access = i_req.request && !ready_q;

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= access;
		end
	end

	// Storage and registered read port
	always_ff @(posedge clock)
	begin
		if (access && i_req.rw)
		begin
			mem[index] <= i_req.wdata;
		end
		if (access)
		begin
			rdata_q <= mem[index];
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

endmodule

// ==== led_port.sv ====
module led_port (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_req,
	output soc_pkg::bus_rsp_t  o_rsp,
	output soc_pkg::led_t      o_led
);

	soc_pkg::led_t led_q;
	logic ready_q;
	logic access;

	assign access = i_req.request && !ready_q;

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			ready_q <= 1'b0;
			led_q <= '0;
		end
		else
		begin
			ready_q <= access;
			// Only the low bits reach the pins
			if (access && i_req.rw)
			begin
				led_q <= i_req.wdata[$bits(soc_pkg::led_t) - 1:0];
			end
		end
	end

	assign o_led = led_q;
	assign o_rsp.ready = ready_q;
	// Readback is the pattern zero-extended
	assign o_rsp.rdata = soc_pkg::word_t'(led_q);

endmodule

// ==== tick_timer.sv ====
`include "soc_cfg.svh"

module tick_timer (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_req,
	output soc_pkg::bus_rsp_t  o_rsp
);

	soc_pkg::word_t prescale_q;
	soc_pkg::word_t count_q;
	soc_pkg::word_t rdata_q;
	logic ready_q;
	logic access;
	logic tick;

	assign access = i_req.request && !ready_q;

	// Last clock of a prescale period
	assign tick = (prescale_q == soc_pkg::word_t'(`SOC_TIMER_DIV - 1));

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			ready_q <= 1'b0;
			prescale_q <= '0;
			count_q <= '0;
		end
		else
		begin
			ready_q <= access;
			if (access && i_req.rw)
			begin
				// Load restarts the prescale period
				count_q <= i_req.wdata;
				prescale_q <= '0;
			end
			else if (tick)
			begin
				count_q <= count_q + 1'b1;
				prescale_q <= '0;
			end
			else
			begin
				prescale_q <= prescale_q + 1'b1;
			end
		end
	end

	// Count captured on the request cycle
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			rdata_q <= count_q;
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

endmodule

// ==== soc_top.sv ====
module soc_top (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_bus,
	output soc_pkg::bus_rsp_t  o_bus,
	output soc_pkg::led_t      o_led
);

	// Per-target request paths
	soc_pkg::bus_req_t ram_req;
	soc_pkg::bus_req_t led_req;
	soc_pkg::bus_req_t timer_req;

	// Per-target response paths
	soc_pkg::bus_rsp_t ram_rsp;
	soc_pkg::bus_rsp_t led_rsp;
	soc_pkg::bus_rsp_t timer_rsp;

	bus_decoder decoder (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_bus       (i_bus),
		.o_bus       (o_bus),
		.o_ram_req   (ram_req),
		.o_led_req   (led_req),
		.o_timer_req (timer_req),
		.i_ram_rsp   (ram_rsp),
		.i_led_rsp   (led_rsp),
		.i_timer_rsp (timer_rsp)
	);

	// Word storage
	block_ram ram (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	// Board LEDs
	led_port led (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (led_req),
		.o_rsp   (led_rsp),
		.o_led   (o_led)
	);

	// Free-running tick count
	tick_timer timer (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (timer_req),
		.o_rsp   (timer_rsp)
	);

endmodule

// ==== soc_checker.sv ====
`include "soc_cfg.svh"

module soc_checker (
	input  logic               clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_bus,
	input  soc_pkg::bus_rsp_t  i_rsp,
	input  soc_pkg::led_t      i_led,
	input  int                 i_test_num,
	input  logic               i_op,
	input  soc_pkg::word_t     i_expected,
	input  logic               i_kind,
	output int                 o_pass_count,
	output int                 o_fail_count
);

	// Edges from the load to the count capture of the read right after it
	localparam int LOAD_TO_READ_CYCLES = 3;
	localparam soc_pkg::word_t TIMER_SLACK = soc_pkg::word_t'(
		(LOAD_TO_READ_CYCLES + `SOC_TIMER_DIV - 1) / `SOC_TIMER_DIV);

	int req_age;
	logic reset_seen;

	task automatic show_mismatch(
		input string          name,
		input string          what,
		input soc_pkg::word_t expected,
		input soc_pkg::word_t actual
	);
		$display("error %s %s: expected 0x%08h, actual 0x%08h", name, what, expected, actual);
	endtask

	task automatic tally(input logic ok, input string name);
		if (ok)
		begin
			o_pass_count++;
			$display("pass %s", name);
		end
		else
		begin
			o_fail_count++;
		end
	endtask

	task automatic verify_reset;
		logic ok;
		ok = 1'b1;
		if (i_rsp.ready !== 1'b0)
		begin
			show_mismatch("reset", "ready", '0, soc_pkg::word_t'(i_rsp.ready));
			ok = 1'b0;
		end
		if (i_led !== '0)
		begin
			show_mismatch("reset", "led", '0, soc_pkg::word_t'(i_led));
			ok = 1'b0;
		end
		tally(ok, "reset");
	endtask

	task automatic compare_transfer;
		string name;
		logic ok;
		soc_pkg::word_t upper;
		name = $sformatf("test_%0d", i_test_num);
		ok = 1'b1;
		upper = i_expected + TIMER_SLACK;
		if (req_age != 1)
		begin
			show_mismatch(name, "latency", soc_pkg::word_t'(1), soc_pkg::word_t'(req_age));
			ok = 1'b0;
		end
		if (!i_op && i_kind)
		begin
			// Count may have moved on by up to the slack since the load
			if ($isunknown(i_rsp.rdata) || i_rsp.rdata < i_expected || i_rsp.rdata > upper)
			begin
				$display("error %s rdata: expected 0x%08h to 0x%08h, actual 0x%08h",
					name, i_expected, upper, i_rsp.rdata);
				ok = 1'b0;
			end
		end
		else if (!i_op)
		begin
			if (i_rsp.rdata !== i_expected)
			begin
				show_mismatch(name, "rdata", i_expected, i_rsp.rdata);
				ok = 1'b0;
			end
		end
		else if (i_led !== i_expected[$bits(soc_pkg::led_t) - 1:0])
		begin
			show_mismatch(name, "led", i_expected, soc_pkg::word_t'(i_led));
			ok = 1'b0;
		end
		tally(ok, name);
	endtask

	always @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			req_age = 0;
			reset_seen = 1'b0;
			o_pass_count = 0;
			o_fail_count = 0;
		end
		else
		begin
			if (!reset_seen)
			begin
				verify_reset();
				reset_seen = 1'b1;
			end
			if (i_rsp.ready)
			begin
				compare_transfer();
			end
			// Edges the request has been held for
			if (i_bus.request)
			begin
				req_age = req_age + 1;
			end
			else
			begin
				req_age = 0;
			end
		end
	end

endmodule

// ==== tb_soc.sv ====
module tb_soc;

	localparam int CLOCK_HALF = 2;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY = 1;
	localparam int READY_TIMEOUT = 20;
	localparam int DRAIN_CYCLES = 3;

	logic clock;
	logic i_rst_n;
	soc_pkg::bus_req_t bus_req;
	soc_pkg::bus_rsp_t bus_rsp;
	soc_pkg::led_t led;

	// Transfer currently on the bus for the checker
	int test_num;
	logic test_op;
	soc_pkg::word_t test_expected;
	logic test_kind;

	int pass_count;
	int fail_count;
	logic timed_out;
	logic file_missing;

	soc_top DUT (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_bus   (bus_req),
		.o_bus   (bus_rsp),
		.o_led   (led)
	);

	soc_checker scoreboard (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_bus        (bus_req),
		.i_rsp        (bus_rsp),
		.i_led        (led),
		.i_test_num   (test_num),
		.i_op         (test_op),
		.i_expected   (test_expected),
		.i_kind       (test_kind),
		.o_pass_count (pass_count),
		.o_fail_count (fail_count)
	);

	initial
	begin
		clock = 1'b0;
		forever #CLOCK_HALF clock = ~clock;
	end

	// Single transfer held until ready or until the timeout
	task automatic run_transfer(
		input  logic           op,
		input  soc_pkg::addr_t addr,
		input  soc_pkg::word_t wdata,
		input  soc_pkg::word_t expected,
		input  logic           kind,
		output logic           no_ready
	);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		@(posedge clock);
		#DRIVE_DELAY;
		test_op = op;
		test_expected = expected;
		test_kind = kind;
		bus_req.request = 1'b1;
		bus_req.rw = op;
		bus_req.address = addr;
		bus_req.wdata = wdata;
		while (!seen && cycles < READY_TIMEOUT)
		begin
			@(posedge clock);
			cycles++;
			seen = (bus_rsp.ready === 1'b1);
		end
		#DRIVE_DELAY;
		bus_req.request = 1'b0;
		no_ready = !seen;
	endtask

	initial
	begin
		int fd;
		int fields;
		string line;
		soc_pkg::word_t f_op;
		soc_pkg::word_t f_addr;
		soc_pkg::word_t f_wdata;
		soc_pkg::word_t f_expected;
		soc_pkg::word_t f_kind;
		i_rst_n = 1'b0;
		bus_req = '0;
		test_num = 0;
		test_op = 1'b0;
		test_expected = '0;
		test_kind = 1'b0;
		timed_out = 1'b0;
		file_missing = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		i_rst_n = 1'b1;

		fd = $fopen("soc_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open soc_stim.txt for reading");
			file_missing = 1'b1;
		end
		else
		begin
			while (!timed_out && !$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// Comment and blank lines match no fields
				fields = $sscanf(line, "%h %h %h %h %h",
					f_op, f_addr, f_wdata, f_expected, f_kind);
				if (fields == 5)
				begin
					test_num++;
					run_transfer(f_op[0], f_addr, f_wdata, f_expected, f_kind[0], timed_out);
					if (timed_out)
					begin
						$display("test_%0d got no ready within %0d cycles",
							test_num, READY_TIMEOUT);
					end
				end
			end
			$fclose(fd);
		end

		// Let the last check land
		repeat (DRAIN_CYCLES) @(posedge clock);
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (file_missing || timed_out || fail_count != 0 || pass_count == 0)
		begin
			$display("Simulation FAILED");
		end
		else
		begin
			$display("Simulation PASSED");
		end
		$finish;
	end

endmodule

// ==== soc_stim.txt ====
# op (0 read, 1 write), address, write data, expected, kind (0 exact, 1 timer range)
# for a write the expected column is the LED pattern after it, all values in hex
1 00010000 deadbeef 00000000 0
1 00010004 12345678 00000000 0
1 000103fc cafef00d 00000000 0
0 00010000 00000000 deadbeef 0
0 00010004 00000000 12345678 0
0 000103fc 00000000 cafef00d 0
0 00010400 00000000 deadbeef 0
0 00010404 00000000 12345678 0
1 50000000 fffff2a5 000002a5 0
0 50000000 00000000 000002a5 0
0 50000004 00000000 000002a5 0
1 50000050 00001000 000002a5 0
0 50000050 00000000 00001000 1
0 30000000 00000000 00000000 0
1 30000000 55555555 000002a5 0
1 00020000 77777777 000002a5 0
0 00010000 00000000 deadbeef 0
1 50000050 0000abcd 000002a5 0
0 50000050 00000000 0000abcd 1

// ==== compile.f ====
+incdir+.
soc_pkg.sv
bus_decoder.sv
block_ram.sv
led_port.sv
tick_timer.sv
soc_top.sv
soc_checker.sv
tb_soc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing
TOP := tb_soc
FILELIST := compile.f
OBJ_DIR := obj_dir
PASS_MSG := Simulation PASSED

.PHONY: all build lint clean

all: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
